/* common/uart_cmd_pkg.sv */
package uart_cmd_pkg;

  // Command and data widths
  localparam int CMD_WIDTH  = 16;
  localparam int BYTE_WIDTH = 8;
  localparam int CMD_OP_BIT = CMD_WIDTH - 1;  // Selects write or read

  // Bit timing, 8 clocks per bit keeps simulation short (434 for 115200 at 50 MHz)
  localparam int CLKS_PER_BIT = 8;
  localparam int BIT_TMR_W    = $clog2(CLKS_PER_BIT);

  localparam logic [BIT_TMR_W-1:0] BIT_TMR_LAST = BIT_TMR_W'(CLKS_PER_BIT - 1);
  localparam logic [BIT_TMR_W-1:0] BIT_TMR_MID  = BIT_TMR_W'(CLKS_PER_BIT / 2 - 1);

  // Start, eight data bits, parity and stop
  localparam int FRAME_BITS  = 11;
  localparam int FRAME_IDX_W = $clog2(FRAME_BITS);

  localparam logic [FRAME_IDX_W-1:0] FRAME_IDX_LAST = FRAME_IDX_W'(FRAME_BITS - 1);
  localparam logic [FRAME_IDX_W-1:0] PARITY_IDX     = FRAME_IDX_W'(FRAME_BITS - 2);

  // Idle time on tx between frames and after a write
  localparam int GAP_CYCLES = 100;
  localparam int GAP_CNT_W  = $clog2(GAP_CYCLES);

  localparam logic [GAP_CNT_W-1:0] GAP_LAST = GAP_CNT_W'(GAP_CYCLES - 1);

  // Wait for a response start bit after the read address frame
  localparam int RESP_TIMEOUT = 400;
  localparam int TMO_CNT_W    = $clog2(RESP_TIMEOUT);

  localparam logic [TMO_CNT_W-1:0] TMO_LAST = TMO_CNT_W'(RESP_TIMEOUT - 1);

  // Command queue
  localparam int FIFO_DEPTH = 4;
  localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
  localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);

  localparam logic [FIFO_PTR_W-1:0] FIFO_PTR_LAST = FIFO_PTR_W'(FIFO_DEPTH - 1);
  localparam logic [FIFO_CNT_W-1:0] FIFO_FULL_CNT = FIFO_CNT_W'(FIFO_DEPTH);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_SEND_ADDR,
    ST_GAP_WAIT,
    ST_SEND_DATA,
    ST_AWAIT_RESP
  } link_state_t;

  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } cmd_op_t;

endpackage

/* src/cmd_fifo.sv */
`timescale 1ns/10ps

module cmd_fifo (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic [uart_cmd_pkg::CMD_WIDTH-1:0] cmd_in,
  input  logic                               cmd_vld,
  output logic                               cmd_rdy,
  input  logic                               fifo_pop,
  output logic [uart_cmd_pkg::CMD_WIDTH-1:0] fifo_cmd,
  output logic                               fifo_empty
);

  logic [uart_cmd_pkg::CMD_WIDTH-1:0]  mem [uart_cmd_pkg::FIFO_DEPTH];
  logic [uart_cmd_pkg::FIFO_PTR_W-1:0] wr_ptr;
  logic [uart_cmd_pkg::FIFO_PTR_W-1:0] rd_ptr;
  logic [uart_cmd_pkg::FIFO_CNT_W-1:0] count;
  logic                                push;
  logic                                pop;

  // A full queue refuses the push even when a pop happens in the same cycle
  assign cmd_rdy    = (count != uart_cmd_pkg::FIFO_FULL_CNT);
  assign fifo_empty = (count == '0);
  assign fifo_cmd   = mem[rd_ptr];

  assign push = cmd_vld & cmd_rdy;
  assign pop  = fifo_pop & ~fifo_empty;

  always_ff @(posedge clk)
  begin
    if (push)
      mem[wr_ptr] <= cmd_in;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (push)
        wr_ptr <= (wr_ptr == uart_cmd_pkg::FIFO_PTR_LAST) ? '0 : wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= (rd_ptr == uart_cmd_pkg::FIFO_PTR_LAST) ? '0 : rd_ptr + 1'b1;

      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // Idle, or push and pop cancel
      endcase
    end
  end

endmodule

/* uart_link/uart_tx.sv */
`timescale 1ns/10ps

module uart_tx (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                tx_start,
  input  logic [uart_cmd_pkg::BYTE_WIDTH-1:0] tx_byte,
  output logic                                tx_busy,
  output logic                                tx
);

  // Bits still to go after the start bit: data LSB first, parity, stop
  logic [uart_cmd_pkg::FRAME_BITS-2:0]  frame_q;
  logic [uart_cmd_pkg::BIT_TMR_W-1:0]   tmr;
  logic [uart_cmd_pkg::FRAME_IDX_W-1:0] bit_idx;
  logic                                 launch;
  logic                                 bit_end;

  assign launch  = tx_start & ~tx_busy;
  assign bit_end = tx_busy && (tmr == uart_cmd_pkg::BIT_TMR_LAST);

  always_ff @(posedge clk)
  begin
    if (launch)
      frame_q <= {1'b1, ~^tx_byte, tx_byte};  // Odd parity over the data byte
    else if (bit_end)
      frame_q <= {1'b1, frame_q[uart_cmd_pkg::FRAME_BITS-2:1]};
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      tx_busy <= 1'b0;
      tx      <= 1'b1;
      tmr     <= '0;
      bit_idx <= '0;
    end
    else if (!tx_busy)
    begin
      if (launch)
      begin
        tx_busy <= 1'b1;
        tx      <= 1'b0;  // Start bit
        tmr     <= '0;
        bit_idx <= '0;
      end
    end
    else if (bit_end)
    begin
      tmr <= '0;
      if (bit_idx == uart_cmd_pkg::FRAME_IDX_LAST)
      begin
        // Stop bit done, the line rests high
        tx_busy <= 1'b0;
        tx      <= 1'b1;
      end
      else
      begin
        bit_idx <= bit_idx + 1'b1;
        tx      <= frame_q[0];
      end
    end
    else
    begin
      tmr <= tmr + 1'b1;
    end
  end

endmodule

/* uart_link/uart_rx.sv */
`timescale 1ns/10ps

module uart_rx (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                rx,
  output logic                                rx_active,
  output logic                                rx_done,
  output logic [uart_cmd_pkg::BYTE_WIDTH-1:0] rx_byte,
  output logic                                rx_fault
);

  logic                                 rx_meta;
  logic                                 rx_sync;
  logic                                 rx_prev;
  logic                                 start_edge;
  logic                                 sample;
  logic [uart_cmd_pkg::BIT_TMR_W-1:0]   tmr;
  logic [uart_cmd_pkg::FRAME_IDX_W-1:0] bit_idx;
  logic [uart_cmd_pkg::BYTE_WIDTH-1:0]  shift_q;
  logic                                 parity_q;

  assign start_edge = rx_prev & ~rx_sync;

  // First sample lands half a bit after the edge, the rest one bit apart
  assign sample = rx_active &&
                  (tmr == ((bit_idx == '0) ? uart_cmd_pkg::BIT_TMR_MID
                                           : uart_cmd_pkg::BIT_TMR_LAST));

  assign rx_byte = shift_q;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end
    else
    begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  always_ff @(posedge clk)
  begin
    if (sample)
    begin
      if (bit_idx == uart_cmd_pkg::PARITY_IDX)
        parity_q <= rx_sync;
      else if (bit_idx != '0 && bit_idx != uart_cmd_pkg::FRAME_IDX_LAST)
        shift_q <= {rx_sync, shift_q[uart_cmd_pkg::BYTE_WIDTH-1:1]};  // LSB arrives first
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rx_active <= 1'b0;
      rx_done   <= 1'b0;
      rx_fault  <= 1'b0;
      tmr       <= '0;
      bit_idx   <= '0;
    end
    else
    begin
      rx_done <= 1'b0;
      if (!rx_active)
      begin
        if (start_edge)
        begin
          rx_active <= 1'b1;
          tmr       <= '0;
          bit_idx   <= '0;
        end
      end
      else if (sample)
      begin
        tmr     <= '0;
        bit_idx <= bit_idx + 1'b1;
        if (bit_idx == '0 && rx_sync)
          rx_active <= 1'b0;  // Start bit gone at mid-bit, treat as a glitch
        else if (bit_idx == uart_cmd_pkg::FRAME_IDX_LAST)
        begin
          rx_active <= 1'b0;
          rx_done   <= 1'b1;
          // Odd parity wants an odd count of ones, and stop must be high
          rx_fault  <= (^{shift_q, parity_q} == 1'b0) | ~rx_sync;
        end
      end
      else
      begin
        tmr <= tmr + 1'b1;
      end
    end
  end

endmodule

/* uart_link/uart_link_ctrl.sv */
`timescale 1ns/10ps

module uart_link_ctrl (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic [uart_cmd_pkg::CMD_WIDTH-1:0]  fifo_cmd,
  input  logic                                fifo_empty,
  output logic                                fifo_pop,
  input  logic                                rx,
  output logic                                tx,
  output logic [uart_cmd_pkg::BYTE_WIDTH-1:0] read_data,
  output logic                                read_rdy,
  output logic                                read_err
);

  uart_cmd_pkg::link_state_t            state;
  logic [uart_cmd_pkg::CMD_WIDTH-1:0]   cmd_q;
  logic                                 data_sent;  // Set once the write data frame is out
  logic [uart_cmd_pkg::GAP_CNT_W-1:0]   gap_cnt;
  logic [uart_cmd_pkg::TMO_CNT_W-1:0]   tmo_cnt;
  logic                                 gap_done;
  logic                                 tx_start;
  logic [uart_cmd_pkg::BYTE_WIDTH-1:0]  tx_byte;
  logic                                 tx_busy;
  logic                                 tx_busy_q;
  logic                                 tx_done;
  logic                                 rx_active;
  logic                                 rx_done;
  logic [uart_cmd_pkg::BYTE_WIDTH-1:0]  rx_byte;
  logic                                 rx_fault;

  assign fifo_pop = (state == uart_cmd_pkg::ST_IDLE) && !fifo_empty;
  assign tx_done  = tx_busy_q & ~tx_busy;  // Falling edge of busy ends a frame
  assign gap_done = (state == uart_cmd_pkg::ST_GAP_WAIT) &&
                    (gap_cnt == uart_cmd_pkg::GAP_LAST);

  uart_tx i_uart_tx (
    .clk      (clk),
    .rst_n    (rst_n),
    .tx_start (tx_start),
    .tx_byte  (tx_byte),
    .tx_busy  (tx_busy),
    .tx       (tx)
  );

  uart_rx i_uart_rx (
    .clk       (clk),
    .rst_n     (rst_n),
    .rx        (rx),
    .rx_active (rx_active),
    .rx_done   (rx_done),
    .rx_byte   (rx_byte),
    .rx_fault  (rx_fault)
  );

  // Address byte goes with the pop, data byte at the end of the first gap
  always_ff @(posedge clk)
  begin
    if (fifo_pop)
    begin
      cmd_q   <= fifo_cmd;
      tx_byte <= fifo_cmd[uart_cmd_pkg::CMD_WIDTH-1 -: uart_cmd_pkg::BYTE_WIDTH];
    end
    else if (gap_done && !data_sent)
      tx_byte <= cmd_q[uart_cmd_pkg::BYTE_WIDTH-1:0];
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state     <= uart_cmd_pkg::ST_IDLE;
      data_sent <= 1'b0;
      gap_cnt   <= '0;
      tmo_cnt   <= '0;
      tx_start  <= 1'b0;
      tx_busy_q <= 1'b0;
      read_data <= '0;
      read_rdy  <= 1'b0;
      read_err  <= 1'b0;
    end
    else
    begin
      tx_start  <= 1'b0;
      read_rdy  <= 1'b0;
      read_err  <= 1'b0;
      tx_busy_q <= tx_busy;
      case (state)
        uart_cmd_pkg::ST_IDLE:
        begin
          if (fifo_pop)
          begin
            tx_start  <= 1'b1;
            data_sent <= 1'b0;
            state     <= uart_cmd_pkg::ST_SEND_ADDR;
          end
        end
        uart_cmd_pkg::ST_SEND_ADDR:
        begin
          if (tx_done)
          begin
            gap_cnt <= '0;
            tmo_cnt <= '0;
            if (cmd_q[uart_cmd_pkg::CMD_OP_BIT] == uart_cmd_pkg::OP_WRITE)
              state <= uart_cmd_pkg::ST_GAP_WAIT;
            else
              state <= uart_cmd_pkg::ST_AWAIT_RESP;
          end
        end
        uart_cmd_pkg::ST_GAP_WAIT:
        begin
          if (!gap_done)
            gap_cnt <= gap_cnt + 1'b1;
          else if (data_sent)
            state <= uart_cmd_pkg::ST_IDLE;
          else
          begin
            tx_start <= 1'b1;
            state    <= uart_cmd_pkg::ST_SEND_DATA;
          end
        end
        uart_cmd_pkg::ST_SEND_DATA:
        begin
          if (tx_done)
          begin
            data_sent <= 1'b1;
            gap_cnt   <= '0;
            state     <= uart_cmd_pkg::ST_GAP_WAIT;
          end
        end
        uart_cmd_pkg::ST_AWAIT_RESP:
        begin
          if (rx_done)
          begin
            if (rx_fault)
              read_err <= 1'b1;  // read_data keeps the last good byte
            else
            begin
              read_rdy  <= 1'b1;
              read_data <= rx_byte;
            end
            state <= uart_cmd_pkg::ST_IDLE;
          end
          else if (!rx_active)
          begin
            // Timer only runs while no frame is coming in
            if (tmo_cnt == uart_cmd_pkg::TMO_LAST)
            begin
              read_err <= 1'b1;
              state    <= uart_cmd_pkg::ST_IDLE;
            end
            else
              tmo_cnt <= tmo_cnt + 1'b1;
          end
        end
        default:
          state <= uart_cmd_pkg::ST_IDLE;
      endcase
    end
  end

endmodule

/* src/uart_cmd_top.sv */
`timescale 1ns/10ps

module uart_cmd_top (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic [uart_cmd_pkg::CMD_WIDTH-1:0]  cmd_in,
  input  logic                                cmd_vld,
  output logic                                cmd_rdy,
  input  logic                                rx,
  output logic                                tx,
  output logic [uart_cmd_pkg::BYTE_WIDTH-1:0] read_data,
  output logic                                read_rdy,
  output logic                                read_err
);

  logic [uart_cmd_pkg::CMD_WIDTH-1:0] fifo_cmd;
  logic                               fifo_empty;
  logic                               fifo_pop;

  // Host commands wait here while the link is busy
  cmd_fifo i_cmd_fifo (
    .clk        (clk),
    .rst_n      (rst_n),
    .cmd_in     (cmd_in),
    .cmd_vld    (cmd_vld),
    .cmd_rdy    (cmd_rdy),
    .fifo_pop   (fifo_pop),
    .fifo_cmd   (fifo_cmd),
    .fifo_empty (fifo_empty)
  );

  uart_link_ctrl i_uart_link_ctrl (
    .clk        (clk),
    .rst_n      (rst_n),
    .fifo_cmd   (fifo_cmd),
    .fifo_empty (fifo_empty),
    .fifo_pop   (fifo_pop),
    .rx         (rx),
    .tx         (tx),
    .read_data  (read_data),
    .read_rdy   (read_rdy),
    .read_err   (read_err)
  );

endmodule

/* testbench/tb_uart_cmd.sv */
`timescale 1ns/10ps

module tb_uart_cmd;

  logic        clk;
  logic        rst_n;
  logic [15:0] cmd_in;
  logic        cmd_vld;
  logic        cmd_rdy;
  logic        rx;
  logic        tx;
  logic [7:0]  read_data;
  logic        read_rdy;
  logic        read_err;

  logic [15:0] cmd_list [$];
  logic [7:0]  rsp_list [$];
  int          op_list [$];
  int          kind_list [$];
  int          idle_list [$];
  int          exp_list [$];
  logic [7:0]  tx_bytes [$];  // Decoded tx frames in arrival order
  time         tx_starts [$];

  int         seed = 32'he908;
  int         cycle = 0;
  int         cycle_limit = 0;
  int         value_errors = 0;
  int         other_errors = 0;
  int         accepted = 0;
  int         frame_starts = 0;
  int         rdy_seen = 0;
  int         err_seen = 0;
  int         exp_rdy = 0;
  int         exp_err = 0;
  logic       stall_seen = 1'b0;
  logic [7:0] pulse_data = '0;  // read_data seen with the latest pulse
  logic [7:0] last_good = '0;

  uart_cmd_top i_dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .rx        (rx),
    .tx        (tx),
    .read_data (read_data),
    .read_rdy  (read_rdy),
    .read_err  (read_err)
  );

  always #50 clk = ~clk;

  always @(posedge clk)
  begin
    cycle++;
    if (cycle >= cycle_limit)
    begin
      $display("Timeout: run stopped after %0d cycles with commands still open", cycle);
      print_counts();
      $display("Simulation failed");
      $finish;
    end
  end

  always @(negedge clk)
  begin
    if (rst_n === 1'b1)
    begin
      if (read_rdy === 1'b1)
      begin
        rdy_seen++;
        pulse_data = read_data;
      end
      if (read_err === 1'b1)
      begin
        err_seen++;
        pulse_data = read_data;
      end
    end
  end

  task automatic report_value(input string name, input logic [15:0] expv,
                              input logic [15:0] actv);
    $display("** Error at %0t ns: %s expected 0x%0h, actual 0x%0h", $time, name, expv, actv);
    value_errors++;
  endtask

  task automatic report_fault(input string msg);
    $display("Failure at %0t ns: %s", $time, msg);
    other_errors++;
  endtask

  task automatic print_counts();
    $display("Error counts: %0d wrong values, %0d other failures", value_errors, other_errors);
  endtask

  task automatic load_stimulus();
    int          fd;
    int          code;
    int          n;
    int          op;
    int          kind;
    int          idle;
    int          expv;
    logic [15:0] cmd;
    logic [7:0]  rsp;
    string       line;
    fd = $fopen("testbench/uart_cmd_stim.txt", "r");
    if (fd == 0)
      report_fault("cannot open testbench/uart_cmd_stim.txt");
    else
    begin
      while (!$feof(fd))
      begin
        code = $fgets(line, fd);
        n = $sscanf(line, "%d %h %h %d %d %d", op, cmd, rsp, kind, idle, expv);
        if (code > 0 && n == 6)  // Comment and blank lines fail the scan
        begin
          op_list.push_back(op);
          cmd_list.push_back(cmd);
          rsp_list.push_back(rsp);
          kind_list.push_back(kind);
          idle_list.push_back(idle);
          exp_list.push_back(expv);
          if (expv == 1)
            exp_rdy++;
          if (expv == 2)
            exp_err++;
        end
      end
      $fclose(fd);
    end
  endtask

  // A write takes two frames and a read one, so the frame count tells how many commands began
  function automatic int commands_started(input int frames);
    int first;
    int n;
    first = 0;
    n = 0;
    foreach (op_list[k])
    begin
      if (first < frames)
        n++;
      first += (op_list[k] == 1) ? 2 : 1;
    end
    return n;
  endfunction

  task automatic host_push(input int idx);
    int extra;
    int waiting;
    extra = 0;
    if (idle_list[idx] > 0)
      extra = int'($unsigned($random(seed)) % 32'd4);
    repeat (idle_list[idx] + extra) @(negedge clk);
    cmd_in  = cmd_list[idx];
    cmd_vld = 1'b1;
    if (!cmd_rdy)
    begin
      // Commands accepted but not yet begun on tx are the ones in the queue
      waiting = accepted - commands_started(frame_starts);
      if (waiting != uart_cmd_pkg::FIFO_DEPTH)
        report_value("commands queued while cmd_rdy is low", 16'(uart_cmd_pkg::FIFO_DEPTH),
                     16'(waiting));
      stall_seen = 1'b1;
    end
    while (!cmd_rdy)
      @(negedge clk);
    @(negedge clk);
    accepted++;
    cmd_vld = 1'b0;
  endtask

  // Decodes every tx frame at mid-bit
  initial
  begin : tx_monitor
    logic [7:0] data;
    logic       par;
    logic       stp;
    time        t0;
    wait (rst_n === 1'b1);
    forever
    begin
      @(negedge tx);
      frame_starts++;
      t0 = $time;
      repeat (uart_cmd_pkg::CLKS_PER_BIT / 2) @(negedge clk);
      if (tx !== 1'b0)
        report_fault("start bit on tx did not last to mid-bit");
      for (int i = 0; i < 8; i++)
      begin
        repeat (uart_cmd_pkg::CLKS_PER_BIT) @(negedge clk);
        data[i] = tx;
      end
      repeat (uart_cmd_pkg::CLKS_PER_BIT) @(negedge clk);
      par = tx;
      repeat (uart_cmd_pkg::CLKS_PER_BIT) @(negedge clk);
      stp = tx;
      if ((^{data, par}) !== 1'b1)
        report_value("tx parity bit", 16'(~^data), 16'(par));
      if (stp !== 1'b1)
        report_value("tx stop bit", 16'd1, 16'(stp));
      tx_bytes.push_back(data);
      tx_starts.push_back(t0);
    end
  end

  task automatic wait_frame(input int idx, input int limit, output logic [7:0] b,
                            output time t, output logic ok);
    int n;
    n = 0;
    b = '0;
    t = 0;
    ok = 1'b0;
    while (tx_bytes.size() == 0 && n < limit)
    begin
      @(posedge clk);
      n++;
    end
    if (tx_bytes.size() == 0)
      report_fault($sformatf("no tx frame arrived for command %0d", idx));
    else
    begin
      b  = tx_bytes.pop_front();
      t  = tx_starts.pop_front();
      ok = 1'b1;
    end
  endtask

  task automatic drive_response(input logic [7:0] data, input int kind);
    logic par;
    par = ~^data;
    if (kind == 1)
      par = ^data;  // Even parity is a fault
    @(negedge clk);
    rx = 1'b0;
    repeat (uart_cmd_pkg::CLKS_PER_BIT) @(negedge clk);
    for (int i = 0; i < 8; i++)
    begin
      rx = data[i];
      repeat (uart_cmd_pkg::CLKS_PER_BIT) @(negedge clk);
    end
    rx = par;
    repeat (uart_cmd_pkg::CLKS_PER_BIT) @(negedge clk);
    rx = (kind == 2) ? 1'b0 : 1'b1;
    repeat (uart_cmd_pkg::CLKS_PER_BIT) @(negedge clk);
    rx = 1'b1;
    repeat (uart_cmd_pkg::CLKS_PER_BIT) @(negedge clk);
  endtask

  task automatic check_command(input int idx);
    logic [7:0] b0;
    logic [7:0] b1;
    time        t0;
    time        t1;
    logic       ok;
    int         frame_cyc;
    int         wait_lim;
    int         gap_cyc;
    int         r0;
    int         e0;
    int         n;
    frame_cyc = uart_cmd_pkg::FRAME_BITS * uart_cmd_pkg::CLKS_PER_BIT;
    wait_lim  = idle_list[idx] + 4 + 3 * frame_cyc + 2 * uart_cmd_pkg::GAP_CYCLES;
    wait_frame(idx, wait_lim, b0, t0, ok);
    if (ok && b0 !== cmd_list[idx][15:8])
      report_value($sformatf("tx address byte, command %0d", idx), 16'(cmd_list[idx][15:8]),
                   16'(b0));
    if (ok && op_list[idx] == 1)
    begin
      wait_frame(idx, wait_lim, b1, t1, ok);
      if (ok && b1 !== cmd_list[idx][7:0])
        report_value($sformatf("tx data byte, command %0d", idx), 16'(cmd_list[idx][7:0]),
                     16'(b1));
      gap_cyc = int'((t1 - t0) / 64'd100);
      if (ok && gap_cyc < frame_cyc + uart_cmd_pkg::GAP_CYCLES)
        report_fault($sformatf("command %0d frames only %0d cycles apart", idx, gap_cyc));
    end
    else if (ok)
    begin
      repeat (2 * uart_cmd_pkg::CLKS_PER_BIT) @(posedge clk);
      r0 = rdy_seen;
      e0 = err_seen;
      if (kind_list[idx] != 3)
        drive_response(rsp_list[idx], kind_list[idx]);
      n = 0;
      while (rdy_seen == r0 && err_seen == e0 && n < uart_cmd_pkg::RESP_TIMEOUT + 2 * frame_cyc)
      begin
        @(posedge clk);
        n++;
      end
      repeat (4) @(posedge clk);
      if (exp_list[idx] == 1)
      begin
        if (rdy_seen - r0 != 1 || err_seen != e0)
          report_fault($sformatf("read %0d wanted one read_rdy, saw %0d read_rdy, %0d read_err",
                                 idx, rdy_seen - r0, err_seen - e0));
        if (pulse_data !== rsp_list[idx])
          report_value("read_data", 16'(rsp_list[idx]), 16'(pulse_data));
        last_good = rsp_list[idx];
      end
      else
      begin
        if (err_seen - e0 != 1 || rdy_seen != r0)
          report_fault($sformatf("read %0d wanted one read_err, saw %0d read_rdy, %0d read_err",
                                 idx, rdy_seen - r0, err_seen - e0));
        if (pulse_data !== last_good)
          report_value("read_data after read_err", 16'(last_good), 16'(pulse_data));
      end
    end
  endtask

  initial
  begin
    clk     = 1'b0;
    rst_n   = 1'b0;
    cmd_in  = '0;
    cmd_vld = 1'b0;
    rx      = 1'b1;
    load_stimulus();
    cycle_limit = 2000;
    foreach (cmd_list[i])
      cycle_limit += 2 * uart_cmd_pkg::FRAME_BITS * uart_cmd_pkg::CLKS_PER_BIT +
                     2 * uart_cmd_pkg::GAP_CYCLES + uart_cmd_pkg::RESP_TIMEOUT + idle_list[i] + 3;
    repeat (4) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    if (tx !== 1'b1)
      report_value("tx after reset", 16'd1, 16'(tx));
    if (cmd_rdy !== 1'b1)
      report_value("cmd_rdy after reset", 16'd1, 16'(cmd_rdy));
    if (read_rdy !== 1'b0)
      report_value("read_rdy after reset", 16'd0, 16'(read_rdy));
    if (read_err !== 1'b0)
      report_value("read_err after reset", 16'd0, 16'(read_err));
    if (read_data !== 8'h00)
      report_value("read_data after reset", 16'd0, 16'(read_data));
    fork
      for (int i = 0; i < cmd_list.size(); i++)
        host_push(i);
      for (int j = 0; j < cmd_list.size(); j++)
        check_command(j);
    join
    repeat (uart_cmd_pkg::GAP_CYCLES + 20) @(negedge clk);
    if (tx_bytes.size() != 0)
      report_fault($sformatf("%0d extra frames appeared on tx", tx_bytes.size()));
    if (rdy_seen != exp_rdy)
      report_value("read_rdy pulse count", 16'(exp_rdy), 16'(rdy_seen));
    if (err_seen != exp_err)
      report_value("read_err pulse count", 16'(exp_err), 16'(err_seen));
    if (!stall_seen)
      report_fault("cmd_rdy never fell while the host pushed back to back");
    print_counts();
    if (value_errors + other_errors == 0)
      $display("Simulation passed");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

/* testbench/uart_cmd_stim.txt */
# op cmd rsp kind idle expect  (cmd and rsp in hex, the rest decimal)
# op 1 write 0 read; kind 0 good 1 parity 2 stop 3 none; expect 0 none 1 read_rdy 2 read_err
1 A53C 00 0 2 0
0 1200 5A 0 3 1
0 3400 C3 1 600 2
0 3500 7E 2 600 2
0 3600 00 3 600 2
1 8001 00 0 5 0
0 0F00 FF 0 700 1
1 9111 00 0 0 0
1 9222 00 0 0 0
0 1300 81 0 0 1
1 9333 00 0 0 0
1 9444 00 0 0 0
0 4700 00 3 0 2
1 FFFF 00 0 0 0
0 7F00 01 0 900 1
1 C0A5 00 0 4 0
0 2100 96 1 0 2
0 2200 3C 0 0 1
1 8000 00 0 1 0
0 0000 00 0 1 1
0 5500 A7 2 3 2
1 B6E9 00 0 0 0
0 6600 E1 0 2 1

/* filelist.f */
common/uart_cmd_pkg.sv
src/cmd_fifo.sv
uart_link/uart_tx.sv
uart_link/uart_rx.sv
uart_link/uart_link_ctrl.sv
src/uart_cmd_top.sv
testbench/tb_uart_cmd.sv

/* Makefile */
SRCS := $(shell grep -v '^+' filelist.f)

obj_dir/Vtb_uart_cmd: filelist.f $(SRCS)
	verilator --binary --timing -j 0 --top-module tb_uart_cmd -f filelist.f

run: obj_dir/Vtb_uart_cmd
	./obj_dir/Vtb_uart_cmd | tee sim.log
	@if grep -q "Simulation failed" sim.log; then \
		echo "Run failed, see sim.log"; exit 1; \
	fi
	@grep -q "Simulation passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean
